// File: files.f
logic/tcdm_pkg.sv
logic/tcdm_fill_engine.sv
logic/tcdm_checksum_engine.sv
logic/tcdm_mux_static.sv
logic/tcdm_bank.sv
logic/tcdm_cluster_top.sv
verification/tcdm_cluster_assert.sv
verification/tb_tcdm_cluster.sv

// File: logic/tcdm_bank.sv
//----------------------------------------------------------
// single-port bank, 2**TCDM_AW words, byte write enables
// grant is combinational, response one cycle after transfer
// memory contents are undefined until written
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_bank (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         stall_i,
  input  logic                         req_i,
  input  logic [tcdm_pkg::TCDM_AW-1:0] add_i,
  input  logic                         wen_i,
  input  logic [tcdm_pkg::TCDM_BW-1:0] be_i,
  input  logic [tcdm_pkg::TCDM_DW-1:0] data_i,
  output logic                         gnt_o,
  output logic                         r_valid_o,
  output logic [tcdm_pkg::TCDM_DW-1:0] r_data_o
);

  import tcdm_pkg::*;

  logic [TCDM_DW-1:0] mem_q [TCDM_NB_WORDS];
  logic               xfer;
  logic               r_valid_q;
  logic [TCDM_DW-1:0] r_data_q;

  // stall_i models a busy bank, it only holds back the grant
  assign xfer  = req_i & ~stall_i;
  assign gnt_o = xfer;

  //----------------------------------------------------------
  // storage
  //----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      if (wen_i) begin
        // read, data registered on the transfer edge
        r_data_q <= mem_q[add_i];
      end else begin
        for (int b = 0; b < TCDM_BW; b++) begin
          if (be_i[b]) begin
            mem_q[add_i][8*b +: 8] <= data_i[8*b +: 8];
          end
        end
      end
    end
  end

  //----------------------------------------------------------
  // response valid, one per transfer, reads and writes alike
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= xfer;
    end
  end

  assign r_valid_o = r_valid_q;
  // r_data holds the last read while a write is answered
  assign r_data_o  = r_data_q;

endmodule

// File: logic/tcdm_checksum_engine.sv
//----------------------------------------------------------
// reads len words from base, wrapping, and sums them mod 2**32
// checksum_o is final from done_o until the next start
// len_i must not be zero, start_i is ignored while busy
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_checksum_engine (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            start_i,
  input  logic [tcdm_pkg::TCDM_AW-1:0]    base_i,
  input  logic [tcdm_pkg::TCDM_LEN_W-1:0] len_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic [tcdm_pkg::TCDM_DW-1:0]    checksum_o,
  output logic                            tcdm_req_o,
  output logic [tcdm_pkg::TCDM_AW-1:0]    tcdm_add_o,
  output logic                            tcdm_wen_o,
  input  logic                            tcdm_gnt_i,
  input  logic                            tcdm_r_valid_i,
  input  logic [tcdm_pkg::TCDM_DW-1:0]    tcdm_r_data_i
);

  import tcdm_pkg::*;

  logic                  busy_q;
  logic                  done_q;
  logic [TCDM_AW-1:0]    base_q;
  logic [TCDM_LEN_W-1:0] len_q;
  // reads granted so far
  logic [TCDM_LEN_W-1:0] issue_cnt_q;
  // read data words received so far
  logic [TCDM_LEN_W-1:0] ack_cnt_q;
  logic [TCDM_DW-1:0]    acc_q;
  logic                  start;
  logic                  xfer;
  logic                  rsp;
  logic                  last_rsp;

  assign start    = start_i & ~busy_q;
  assign xfer     = tcdm_req_o & tcdm_gnt_i;
  assign rsp      = busy_q & tcdm_r_valid_i;
  assign last_rsp = rsp & (ack_cnt_q == len_q - TCDM_LEN_W'(1));

  //----------------------------------------------------------
  // read requests
  //----------------------------------------------------------
  assign tcdm_req_o = busy_q & (issue_cnt_q != len_q);
  // 8-bit add wraps at the top of the bank
  assign tcdm_add_o = base_q + issue_cnt_q[TCDM_AW-1:0];
  // wen high means read
  assign tcdm_wen_o = 1'b1;

  always_ff @(posedge clk_i) begin
    if (start) begin
      base_q <= base_i;
      len_q  <= len_i;
    end
  end

  //----------------------------------------------------------
  // control, counters and accumulator
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      issue_cnt_q <= '0;
      ack_cnt_q   <= '0;
      acc_q       <= '0;
    end else begin
      done_q <= last_rsp;
      if (start) begin
        busy_q      <= 1'b1;
        issue_cnt_q <= '0;
        ack_cnt_q   <= '0;
        acc_q       <= '0;
      end else if (busy_q) begin
        if (xfer) begin
          issue_cnt_q <= issue_cnt_q + TCDM_LEN_W'(1);
        end
        // responses are in order, one per granted read
        if (rsp) begin
          ack_cnt_q <= ack_cnt_q + TCDM_LEN_W'(1);
          acc_q     <= acc_q + tcdm_r_data_i;
        end
        if (last_rsp) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  // partial sum while busy, final sum once done
  assign checksum_o = acc_q;

endmodule

// File: logic/tcdm_cluster_top.sv
//----------------------------------------------------------
// fill and checksum engines sharing one bank via a static mux
// software runs one engine at a time and sets sel_i to match
// sel_i may only change while the engine it leaves is idle
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_cluster_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [tcdm_pkg::TCDM_SEL_W-1:0] sel_i,
  input  logic                            stall_i,
  // fill engine job
  input  logic                            fill_start_i,
  input  logic [tcdm_pkg::TCDM_AW-1:0]    fill_base_i,
  input  logic [tcdm_pkg::TCDM_LEN_W-1:0] fill_len_i,
  input  logic [tcdm_pkg::TCDM_DW-1:0]    fill_seed_i,
  output logic                            fill_busy_o,
  output logic                            fill_done_o,
  // checksum engine job
  input  logic                            sum_start_i,
  input  logic [tcdm_pkg::TCDM_AW-1:0]    sum_base_i,
  input  logic [tcdm_pkg::TCDM_LEN_W-1:0] sum_len_i,
  output logic                            sum_busy_o,
  output logic                            sum_done_o,
  output logic [tcdm_pkg::TCDM_DW-1:0]    sum_checksum_o
);

  import tcdm_pkg::*;

  //----------------------------------------------------------
  // mux lanes, indexed by the select codes
  //----------------------------------------------------------
  logic [TCDM_NB_CHAN-1:0]              in_req;
  logic [TCDM_NB_CHAN-1:0][TCDM_AW-1:0] in_add;
  logic [TCDM_NB_CHAN-1:0]              in_wen;
  logic [TCDM_NB_CHAN-1:0][TCDM_BW-1:0] in_be;
  logic [TCDM_NB_CHAN-1:0][TCDM_DW-1:0] in_data;
  logic [TCDM_NB_CHAN-1:0]              in_gnt;
  logic [TCDM_NB_CHAN-1:0]              in_r_valid;
  logic [TCDM_NB_CHAN-1:0][TCDM_DW-1:0] in_r_data;

  // bank link
  logic               bank_req;
  logic [TCDM_AW-1:0] bank_add;
  logic               bank_wen;
  logic [TCDM_BW-1:0] bank_be;
  logic [TCDM_DW-1:0] bank_data;
  logic               bank_gnt;
  logic               bank_r_valid;
  logic [TCDM_DW-1:0] bank_r_data;

  // checksum lane only reads, no write payload
  assign in_be[TCDM_SEL_CHECKSUM]   = '0;
  assign in_data[TCDM_SEL_CHECKSUM] = '0;

  tcdm_fill_engine i_fill (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .start_i        (fill_start_i),
    .base_i         (fill_base_i),
    .len_i          (fill_len_i),
    .seed_i         (fill_seed_i),
    .busy_o         (fill_busy_o),
    .done_o         (fill_done_o),
    .tcdm_req_o     (in_req[TCDM_SEL_FILL]),
    .tcdm_add_o     (in_add[TCDM_SEL_FILL]),
    .tcdm_wen_o     (in_wen[TCDM_SEL_FILL]),
    .tcdm_be_o      (in_be[TCDM_SEL_FILL]),
    .tcdm_data_o    (in_data[TCDM_SEL_FILL]),
    .tcdm_gnt_i     (in_gnt[TCDM_SEL_FILL]),
    .tcdm_r_valid_i (in_r_valid[TCDM_SEL_FILL])
  );

  tcdm_checksum_engine i_checksum (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .start_i        (sum_start_i),
    .base_i         (sum_base_i),
    .len_i          (sum_len_i),
    .busy_o         (sum_busy_o),
    .done_o         (sum_done_o),
    .checksum_o     (sum_checksum_o),
    .tcdm_req_o     (in_req[TCDM_SEL_CHECKSUM]),
    .tcdm_add_o     (in_add[TCDM_SEL_CHECKSUM]),
    .tcdm_wen_o     (in_wen[TCDM_SEL_CHECKSUM]),
    .tcdm_gnt_i     (in_gnt[TCDM_SEL_CHECKSUM]),
    .tcdm_r_valid_i (in_r_valid[TCDM_SEL_CHECKSUM]),
    .tcdm_r_data_i  (in_r_data[TCDM_SEL_CHECKSUM])
  );

  tcdm_mux_static i_mux (
    .sel_i         (sel_i),
    .in_req_i      (in_req),
    .in_add_i      (in_add),
    .in_wen_i      (in_wen),
    .in_be_i       (in_be),
    .in_data_i     (in_data),
    .in_gnt_o      (in_gnt),
    .in_r_valid_o  (in_r_valid),
    .in_r_data_o   (in_r_data),
    .out_req_o     (bank_req),
    .out_add_o     (bank_add),
    .out_wen_o     (bank_wen),
    .out_be_o      (bank_be),
    .out_data_o    (bank_data),
    .out_gnt_i     (bank_gnt),
    .out_r_valid_i (bank_r_valid),
    .out_r_data_i  (bank_r_data)
  );

  tcdm_bank i_bank (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .stall_i   (stall_i),
    .req_i     (bank_req),
    .add_i     (bank_add),
    .wen_i     (bank_wen),
    .be_i      (bank_be),
    .data_i    (bank_data),
    .gnt_o     (bank_gnt),
    .r_valid_o (bank_r_valid),
    .r_data_o  (bank_r_data)
  );

endmodule

// File: logic/tcdm_fill_engine.sv
//----------------------------------------------------------
// writes seed+i to word base+i for i in 0..len-1
// addresses wrap inside the bank, len_i must not be zero
// start_i is ignored while busy_o is high
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_fill_engine (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            start_i,
  input  logic [tcdm_pkg::TCDM_AW-1:0]    base_i,
  input  logic [tcdm_pkg::TCDM_LEN_W-1:0] len_i,
  input  logic [tcdm_pkg::TCDM_DW-1:0]    seed_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            tcdm_req_o,
  output logic [tcdm_pkg::TCDM_AW-1:0]    tcdm_add_o,
  output logic                            tcdm_wen_o,
  output logic [tcdm_pkg::TCDM_BW-1:0]    tcdm_be_o,
  output logic [tcdm_pkg::TCDM_DW-1:0]    tcdm_data_o,
  input  logic                            tcdm_gnt_i,
  input  logic                            tcdm_r_valid_i
);

  import tcdm_pkg::*;

  logic                  busy_q;
  logic                  done_q;
  logic [TCDM_AW-1:0]    base_q;
  logic [TCDM_LEN_W-1:0] len_q;
  logic [TCDM_DW-1:0]    seed_q;
  // requests granted so far, also the index of the next word
  logic [TCDM_LEN_W-1:0] issue_cnt_q;
  // write responses seen so far
  logic [TCDM_LEN_W-1:0] ack_cnt_q;
  logic                  start;
  logic                  xfer;
  logic                  last_rsp;

  assign start    = start_i & ~busy_q;
  assign xfer     = tcdm_req_o & tcdm_gnt_i;
  assign last_rsp = busy_q & tcdm_r_valid_i & (ack_cnt_q == len_q - TCDM_LEN_W'(1));

  //----------------------------------------------------------
  // request side
  //----------------------------------------------------------
  // payload only moves on a grant, so it is stable while stalled
  assign tcdm_req_o  = busy_q & (issue_cnt_q != len_q);
  assign tcdm_add_o  = base_q + issue_cnt_q[TCDM_AW-1:0];
  assign tcdm_wen_o  = 1'b0;
  assign tcdm_be_o   = '1;
  assign tcdm_data_o = seed_q + TCDM_DW'(issue_cnt_q);

  // job parameters
  always_ff @(posedge clk_i) begin
    if (start) begin
      base_q <= base_i;
      len_q  <= len_i;
      seed_q <= seed_i;
    end
  end

  //----------------------------------------------------------
  // control and counters
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      issue_cnt_q <= '0;
      ack_cnt_q   <= '0;
    end else begin
      // done goes high in the cycle busy drops
      done_q <= last_rsp;
      if (start) begin
        busy_q      <= 1'b1;
        issue_cnt_q <= '0;
        ack_cnt_q   <= '0;
      end else if (busy_q) begin
        if (xfer) begin
          issue_cnt_q <= issue_cnt_q + TCDM_LEN_W'(1);
        end
        if (tcdm_r_valid_i) begin
          ack_cnt_q <= ack_cnt_q + TCDM_LEN_W'(1);
        end
        if (last_rsp) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

// File: logic/tcdm_mux_static.sv
//----------------------------------------------------------
// static TCDM mux, no arbitration at all
// lanes must be used strictly one at a time, sel_i may only
// change while the lane it leaves has no request in flight
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_mux_static (
  input  logic [tcdm_pkg::TCDM_SEL_W-1:0]                           sel_i,
  // initiator lanes
  input  logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_req_i,
  input  logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_AW-1:0]  in_add_i,
  input  logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_wen_i,
  input  logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_BW-1:0]  in_be_i,
  input  logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_DW-1:0]  in_data_i,
  output logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_gnt_o,
  output logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_r_valid_o,
  output logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_DW-1:0]  in_r_data_o,
  // target side
  output logic                                                      out_req_o,
  output logic [tcdm_pkg::TCDM_AW-1:0]                              out_add_o,
  output logic                                                      out_wen_o,
  output logic [tcdm_pkg::TCDM_BW-1:0]                              out_be_o,
  output logic [tcdm_pkg::TCDM_DW-1:0]                              out_data_o,
  input  logic                                                      out_gnt_i,
  input  logic                                                      out_r_valid_i,
  input  logic [tcdm_pkg::TCDM_DW-1:0]                              out_r_data_i
);

  import tcdm_pkg::*;

  //----------------------------------------------------------
  // response path, per lane
  //----------------------------------------------------------
  for (genvar ii = 0; ii < TCDM_NB_CHAN; ii++) begin : gen_lane
    // unselected lane sees no grant, so its request just waits
    assign in_gnt_o[ii]     = (sel_i == TCDM_SEL_W'(ii)) ? out_gnt_i     : 1'b0;
    assign in_r_valid_o[ii] = (sel_i == TCDM_SEL_W'(ii)) ? out_r_valid_i : 1'b0;
    // read data is harmless to broadcast, r_valid qualifies it
    assign in_r_data_o[ii]  = out_r_data_i;
  end

  //----------------------------------------------------------
  // request path
  //----------------------------------------------------------
  assign out_req_o  = in_req_i[sel_i];
  assign out_add_o  = in_add_i[sel_i];
  assign out_wen_o  = in_wen_i[sel_i];
  assign out_be_o   = in_be_i[sel_i];
  assign out_data_o = in_data_i[sel_i];

endmodule

// File: logic/tcdm_pkg.sv
//----------------------------------------------------------
// widths and select codes shared by the whole cluster
// the bank is word addressed, 2**TCDM_AW words deep
// region lengths are 1 to TCDM_NB_WORDS, zero is not legal
//----------------------------------------------------------
package tcdm_pkg;

  //----------------------------------------------------------
  // bus geometry
  //----------------------------------------------------------
  // word address width
  localparam int unsigned TCDM_AW       = 8;
  localparam int unsigned TCDM_NB_WORDS = 1 << TCDM_AW;
  // data word and byte enables
  localparam int unsigned TCDM_DW = 32;
  localparam int unsigned TCDM_BW = TCDM_DW / 8;
  // one extra bit so a full-bank region fits
  localparam int unsigned TCDM_LEN_W = TCDM_AW + 1;

  //----------------------------------------------------------
  // static mux
  //----------------------------------------------------------
  localparam int unsigned TCDM_NB_CHAN = 2;
  localparam int unsigned TCDM_SEL_W   = $clog2(TCDM_NB_CHAN);
  // lane 0 is the fill engine, lane 1 the checksum engine
  localparam logic [TCDM_SEL_W-1:0] TCDM_SEL_FILL     = TCDM_SEL_W'(0);
  localparam logic [TCDM_SEL_W-1:0] TCDM_SEL_CHECKSUM = TCDM_SEL_W'(1);

endpackage

// File: verification/tb_tcdm_cluster.sv
//----------------------------------------------------------
// self-checking testbench for tcdm_cluster_top
// inputs change on the falling edge, outputs sampled there too
// checksum regions only cover words written by earlier fills
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_tcdm_cluster;

  import tcdm_pkg::*;

  // 18 jobs of up to a full bank, four cycles per word at worst
  localparam int NB_JOBS        = 18;
  localparam int TIMEOUT_CYCLES = ((NB_JOBS * TCDM_NB_WORDS * 4) / 10000 + 1) * 10000;

  logic                  clk;
  logic                  arst_n;
  logic [TCDM_SEL_W-1:0] sel;
  logic                  stall;
  logic                  fill_start;
  logic [TCDM_AW-1:0]    fill_base;
  logic [TCDM_LEN_W-1:0] fill_len;
  logic [TCDM_DW-1:0]    fill_seed;
  logic                  fill_busy_o;
  logic                  fill_done_o;
  logic                  sum_start;
  logic [TCDM_AW-1:0]    sum_base;
  logic [TCDM_LEN_W-1:0] sum_len;
  logic                  sum_busy_o;
  logic                  sum_done_o;
  logic [TCDM_DW-1:0]    sum_checksum_o;

  // reference copy of the bank, written on every fill
  logic [TCDM_DW-1:0] mem_model [TCDM_NB_WORDS];

  int          seed          = 28;
  int          err_cnt       = 0;
  int          err_mark      = 0;
  int          test_cnt      = 0;
  int          test_fail_cnt = 0;
  int          cycle_cnt     = 0;
  int unsigned fill_done_cnt = 0;
  int unsigned sum_done_cnt  = 0;
  bit          stall_on      = 1'b0;

  tcdm_cluster_top uut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .sel_i          (sel),
    .stall_i        (stall),
    .fill_start_i   (fill_start),
    .fill_base_i    (fill_base),
    .fill_len_i     (fill_len),
    .fill_seed_i    (fill_seed),
    .fill_busy_o    (fill_busy_o),
    .fill_done_o    (fill_done_o),
    .sum_start_i    (sum_start),
    .sum_base_i     (sum_base),
    .sum_len_i      (sum_len),
    .sum_busy_o     (sum_busy_o),
    .sum_done_o     (sum_done_o),
    .sum_checksum_o (sum_checksum_o)
  );

  always #5 clk = ~clk;

  //----------------------------------------------------------
  // background: stalls, done pulse counters, run limit
  //----------------------------------------------------------
  // bank busy one cycle in four while enabled
  always @(negedge clk) begin
    if (stall_on) begin
      stall <= (($random(seed) & 3) == 0);
    end else begin
      stall <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (fill_done_o) begin
      fill_done_cnt <= fill_done_cnt + 1;
    end
    if (sum_done_o) begin
      sum_done_cnt <= sum_done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, an engine never signalled done", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  //----------------------------------------------------------
  // models and checks
  //----------------------------------------------------------
  // sum of seed+i for i below len, closed form
  function automatic logic [TCDM_DW-1:0] pattern_sum(input logic [TCDM_LEN_W-1:0] len,
                                                      input logic [TCDM_DW-1:0] pat_seed);
    logic [TCDM_DW-1:0] l;
    l = TCDM_DW'(len);
    return l * pat_seed + (l * (l - 1)) / 2;
  endfunction

  // sum over the memory model, wrapping at the top
  function automatic logic [TCDM_DW-1:0] region_sum(input logic [TCDM_AW-1:0] base,
                                                     input logic [TCDM_LEN_W-1:0] len);
    logic [TCDM_DW-1:0] acc;
    logic [TCDM_AW-1:0] addr;
    int                 i;
    acc = '0;
    for (i = 0; i < len; i++) begin
      addr = base + TCDM_AW'(i);
      acc  = acc + mem_model[addr];
    end
    return acc;
  endfunction

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %-16s ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %-16s failed with %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // switched on a rising edge so stall draws never race the main flow
  task automatic set_stalls(input bit on);
    @(posedge clk);
    stall_on = on;
    @(negedge clk);
  endtask

  //----------------------------------------------------------
  // job drivers, all called on a falling edge
  //----------------------------------------------------------
  task automatic run_fill(input logic [TCDM_AW-1:0] base, input logic [TCDM_LEN_W-1:0] len,
                          input logic [TCDM_DW-1:0] pat_seed);
    logic [TCDM_AW-1:0] addr;
    int                 i;
    fill_base  = base;
    fill_len   = len;
    fill_seed  = pat_seed;
    fill_start = 1'b1;
    @(negedge clk);
    fill_start = 1'b0;
    while (fill_done_o !== 1'b1) @(negedge clk);
    // one more edge so the pulse counter has caught up
    @(negedge clk);
    for (i = 0; i < len; i++) begin
      addr            = base + TCDM_AW'(i);
      mem_model[addr] = pat_seed + TCDM_DW'(i);
    end
  endtask

  task automatic start_checksum(input logic [TCDM_AW-1:0] base,
                                input logic [TCDM_LEN_W-1:0] len);
    sum_base  = base;
    sum_len   = len;
    sum_start = 1'b1;
    @(negedge clk);
    sum_start = 1'b0;
  endtask

  task automatic wait_checksum(output logic [TCDM_DW-1:0] result);
    while (sum_done_o !== 1'b1) @(negedge clk);
    result = sum_checksum_o;
    @(negedge clk);
  endtask

  task automatic check_region(input logic [TCDM_AW-1:0] base,
                              input logic [TCDM_LEN_W-1:0] len,
                              output logic [TCDM_DW-1:0] result);
    start_checksum(base, len);
    wait_checksum(result);
    expect_value("sum_checksum_o", result, region_sum(base, len));
  endtask

  //----------------------------------------------------------
  // tests
  //----------------------------------------------------------
  task automatic fill_then_checksum(input string name, input bit with_stalls);
    logic [31:0]           r;
    logic [TCDM_AW-1:0]    base;
    logic [TCDM_LEN_W-1:0] len;
    logic [TCDM_DW-1:0]    pat_seed;
    logic [TCDM_DW-1:0]    result;
    int unsigned           fills_before;
    int unsigned           sums_before;
    r            = $random(seed);
    base         = r[TCDM_AW-1:0];
    len          = TCDM_LEN_W'(1 + ($random(seed) & 255));
    pat_seed     = $random(seed);
    fills_before = fill_done_cnt;
    sums_before  = sum_done_cnt;
    if (with_stalls) begin
      set_stalls(1'b1);
    end
    sel = TCDM_SEL_FILL;
    run_fill(base, len, pat_seed);
    sel = TCDM_SEL_CHECKSUM;
    check_region(base, len, result);
    expect_value("sum_checksum_o", result, pattern_sum(len, pat_seed));
    if (with_stalls) begin
      set_stalls(1'b0);
    end
    expect_value("fill_done_o pulses", fill_done_cnt - fills_before, 1);
    expect_value("sum_done_o pulses", sum_done_cnt - sums_before, 1);
    end_test(name);
  endtask

  task automatic static_select();
    logic [31:0]           r;
    logic [TCDM_AW-1:0]    base;
    logic [TCDM_LEN_W-1:0] len;
    logic [TCDM_DW-1:0]    pat_seed;
    logic [TCDM_DW-1:0]    result;
    int unsigned           sums_before;
    r           = $random(seed);
    base        = r[TCDM_AW-1:0];
    len         = TCDM_LEN_W'(1 + ($random(seed) & 255));
    pat_seed    = $random(seed);
    sums_before = sum_done_cnt;
    sel         = TCDM_SEL_FILL;
    // checksum request parks, its lane sees no grant
    start_checksum(base, len);
    repeat (50) begin
      expect_value("sum_busy_o", 32'(sum_busy_o), 32'd1);
      expect_value("sum_done_o", 32'(sum_done_o), 32'd0);
      @(negedge clk);
    end
    run_fill(base, len, pat_seed);
    sel = TCDM_SEL_CHECKSUM;
    wait_checksum(result);
    expect_value("sum_checksum_o", result, region_sum(base, len));
    expect_value("sum_done_o pulses", sum_done_cnt - sums_before, 1);
    end_test("static_select");
  endtask

  // region a always crosses word 255, b lands somewhere inside a
  task automatic wrap_overlap();
    logic [31:0]           r;
    logic [TCDM_AW-1:0]    base_a;
    logic [TCDM_AW-1:0]    base_b;
    logic [TCDM_LEN_W-1:0] len_a;
    logic [TCDM_LEN_W-1:0] len_b;
    logic [TCDM_DW-1:0]    seed_a;
    logic [TCDM_DW-1:0]    seed_b;
    logic [TCDM_DW-1:0]    result;
    int                    round;
    for (round = 0; round < 4; round++) begin
      r      = $random(seed);
      len_a  = TCDM_LEN_W'(32 + (r & 127));
      r      = $random(seed);
      base_a = TCDM_AW'(255 - (r % (len_a - 1)));
      r      = $random(seed);
      base_b = base_a + TCDM_AW'(r % len_a);
      len_b  = TCDM_LEN_W'(1 + ($random(seed) & 63));
      seed_a = $random(seed);
      seed_b = $random(seed);
      sel    = TCDM_SEL_FILL;
      run_fill(base_a, len_a, seed_a);
      run_fill(base_b, len_b, seed_b);
      sel = TCDM_SEL_CHECKSUM;
      check_region(base_a, len_a, result);
    end
    end_test("wrap_overlap");
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    sel        = TCDM_SEL_FILL;
    stall      = 1'b0;
    fill_start = 1'b0;
    fill_base  = '0;
    fill_len   = TCDM_LEN_W'(1);
    fill_seed  = '0;
    sum_start  = 1'b0;
    sum_base   = '0;
    sum_len    = TCDM_LEN_W'(1);
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // outputs idle right after reset
    expect_value("fill_busy_o", 32'(fill_busy_o), 32'd0);
    expect_value("fill_done_o", 32'(fill_done_o), 32'd0);
    expect_value("sum_busy_o", 32'(sum_busy_o), 32'd0);
    expect_value("sum_done_o", 32'(sum_done_o), 32'd0);
    expect_value("sum_checksum_o", sum_checksum_o, 32'd0);
    end_test("reset");

    fill_then_checksum("fill_checksum", 1'b0);
    fill_then_checksum("back_pressure", 1'b1);
    static_select();
    wrap_overlap();

    $display("%0d tests run, %0d failed, %0d check errors, %0d protocol errors",
             test_cnt, test_fail_cnt, err_cnt, uut.i_assert.fail_cnt);
    if (err_cnt == 0 && uut.i_assert.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verification/tcdm_cluster_assert.sv
//----------------------------------------------------------
// TCDM protocol checks, bound into tcdm_cluster_top
// samples on the rising clock edge, idle while reset is low
//----------------------------------------------------------
`timescale 1ns/100ps

module tcdm_cluster_assert (
  input logic                                                      clk_i,
  input logic                                                      arst_n_i,
  input logic [tcdm_pkg::TCDM_SEL_W-1:0]                           sel_i,
  input logic                                                      bank_req_i,
  input logic                                                      bank_gnt_i,
  input logic                                                      bank_r_valid_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_req_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_AW-1:0]  in_add_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_wen_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_BW-1:0]  in_be_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0][tcdm_pkg::TCDM_DW-1:0]  in_data_i,
  input logic [tcdm_pkg::TCDM_NB_CHAN-1:0]                         in_gnt_i,
  input logic                                                      fill_busy_i,
  input logic                                                      sum_busy_i
);

  import tcdm_pkg::*;

  // number of assertion failures so far
  int unsigned fail_cnt = 0;

  // every bank transfer is answered exactly one cycle later
  a_rsp_after_xfer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bank_req_i && bank_gnt_i |=> bank_r_valid_i)
    else begin
      fail_cnt++;
      $error("bank transfer without r_valid one cycle later");
    end

  // grant only reaches the selected lane
  a_gnt_fill_sel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_gnt_i[TCDM_SEL_FILL] |-> sel_i == TCDM_SEL_FILL)
    else begin
      fail_cnt++;
      $error("fill lane granted while not selected");
    end

  a_gnt_sum_sel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_gnt_i[TCDM_SEL_CHECKSUM] |-> sel_i == TCDM_SEL_CHECKSUM)
    else begin
      fail_cnt++;
      $error("checksum lane granted while not selected");
    end

  // a waiting request keeps req and payload until granted
  for (genvar ii = 0; ii < TCDM_NB_CHAN; ii++) begin : gen_hold
    a_payload_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      in_req_i[ii] && !in_gnt_i[ii] |=> in_req_i[ii] && $stable(in_add_i[ii])
        && $stable(in_wen_i[ii]) && $stable(in_be_i[ii]) && $stable(in_data_i[ii]))
      else begin
        fail_cnt++;
        $error("request dropped or payload changed before grant");
      end
  end

  // first edge after reset release sees both engines idle
  a_idle_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !fill_busy_i && !sum_busy_i)
    else begin
      fail_cnt++;
      $error("engine busy right after reset");
    end

endmodule

bind tcdm_cluster_top tcdm_cluster_assert i_assert (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .sel_i          (sel_i),
  .bank_req_i     (bank_req),
  .bank_gnt_i     (bank_gnt),
  .bank_r_valid_i (bank_r_valid),
  .in_req_i       (in_req),
  .in_add_i       (in_add),
  .in_wen_i       (in_wen),
  .in_be_i        (in_be),
  .in_data_i      (in_data),
  .in_gnt_i       (in_gnt),
  .fill_busy_i    (fill_busy_o),
  .sum_busy_i     (sum_busy_o)
);
